// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = int_cluster_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/exe.sv
`timescale 1ns/1ps

module exe (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 iss_valid,
    input  instr_pkg::t_uop      iss_uop,
    input  instr_pkg::t_optype   iss_src2_type,
    input  instr_pkg::t_optype   iss_dst_type,
    input  instr_pkg::t_rv_data  rd1_data,
    input  instr_pkg::t_rv_data  rd2_data,
    input  instr_pkg::t_rv_data  iss_imm,
    input  instr_pkg::t_rv_data  iss_pc,
    input  logic                 iss_pred_taken,
    input  rob_pkg::t_prf_id     iss_pdst,
    input  rob_pkg::t_rob_id     iss_robid,
    input  logic                 br_mispred_rb1,
    output logic                 wr_en,
    output rob_pkg::t_prf_id     wr_pdst,
    output instr_pkg::t_rv_data  wr_data,
    output logic                 ro_valid,
    output rob_pkg::t_rob_id     ro_robid,
    output logic                 ro_mispred
);

    typedef struct packed {
        instr_pkg::t_rv_data result;
        logic                mispred;
    } t_res_payload;

    typedef struct packed {
        rob_pkg::t_prf_id pdst;
        rob_pkg::t_rob_id robid;
        logic             dst_reg;
    } t_ctl_payload;

    instr_pkg::t_rv_data src1_ex0;
    instr_pkg::t_rv_data src2_ex0;

    logic                ialu_resvld_ex0;
    instr_pkg::t_rv_data ialu_result_ex0;
    logic                ibr_resvld_ex0;
    instr_pkg::t_rv_data ibr_result_ex0;
    logic                ibr_mispred_ex0;

    t_res_payload        res_ex0;
    t_res_payload        res_ex1;
    t_ctl_payload        ctl_ex0;
    t_ctl_payload        ctl_ex1;
    logic                res_valid_ex1;
    logic                ctl_valid_ex1;

    // EX0 operand select
    assign src1_ex0 = rd1_data;

    always_comb begin
        src2_ex0 = '0;
        if (iss_src2_type == instr_pkg::OP_REG) begin
            src2_ex0 = rd2_data;
        end else if (iss_src2_type == instr_pkg::OP_IMM) begin
            src2_ex0 = iss_imm;
        end
    end

    ialu u_ialu (
        .uop    (iss_uop),
        .src1   (src1_ex0),
        .src2   (src2_ex0),
        .resvld (ialu_resvld_ex0),
        .result (ialu_result_ex0)
    );

    ibr u_ibr (
        .uop        (iss_uop),
        .src1       (src1_ex0),
        .src2       (src2_ex0),
        .pc         (iss_pc),
        .imm        (iss_imm),
        .pred_taken (iss_pred_taken),
        .resvld     (ibr_resvld_ex0),
        .br_result  (ibr_result_ex0),
        .mispred    (ibr_mispred_ex0)
    );

    // At most one unit claims a micro-op
    always_comb begin
        res_ex0.result = (ialu_resvld_ex0 ? ialu_result_ex0 : '0)
                       | (ibr_resvld_ex0 ? ibr_result_ex0 : '0);
        res_ex0.mispred = ibr_mispred_ex0;
    end

    always_comb begin
        ctl_ex0.pdst    = iss_pdst;
        ctl_ex0.robid   = iss_robid;
        ctl_ex0.dst_reg = (iss_dst_type == instr_pkg::OP_REG);
    end

    exe_stage_reg #(.payload_t(t_res_payload)) u_res_reg (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (br_mispred_rb1),
        .valid_in  (iss_valid),
        .data_in   (res_ex0),
        .valid_out (res_valid_ex1),
        .data_out  (res_ex1)
    );

    exe_stage_reg #(.payload_t(t_ctl_payload)) u_ctl_reg (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (br_mispred_rb1),
        .valid_in  (iss_valid),
        .data_in   (ctl_ex0),
        .valid_out (ctl_valid_ex1),
        .data_out  (ctl_ex1)
    );

    // EX1 outputs
    assign ro_valid   = res_valid_ex1;
    assign ro_robid   = ctl_ex1.robid;
    assign ro_mispred = res_valid_ex1 & res_ex1.mispred;
    assign wr_en      = ctl_valid_ex1 & ctl_ex1.dst_reg;
    assign wr_pdst    = ctl_ex1.pdst;
    assign wr_data    = res_ex1.result;

    a_one_unit: assert property (
        @(posedge clk) disable iff (reset)
        iss_valid |-> $onehot({iss_uop == instr_pkg::U_INVALID,
                               ialu_resvld_ex0, ibr_resvld_ex0})
    ) else $error("exe: issued micro-op not claimed by exactly one unit");

endmodule

// File: logic/exe_stage_reg.sv
`timescale 1ns/1ps

module exe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_out <= 1'b0;
        end else if (!stall) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            data_out <= data_in;
        end
    end

    a_flush_clears: assert property (
        @(posedge clk) flush |=> !valid_out
    ) else $error("exe_stage_reg: valid after flush");

endmodule

// File: logic/ialu.sv
`timescale 1ns/1ps

module ialu (
    input  instr_pkg::t_uop     uop,
    input  instr_pkg::t_rv_data src1,
    input  instr_pkg::t_rv_data src2,
    output logic                resvld,
    output instr_pkg::t_rv_data result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        resvld = 1'b1;
        result = '0;
        case (uop)
            instr_pkg::U_ADD:  result = src1 + src2;
            instr_pkg::U_SUB:  result = src1 - src2;
            instr_pkg::U_AND:  result = src1 & src2;
            instr_pkg::U_OR:   result = src1 | src2;
            instr_pkg::U_XOR:  result = src1 ^ src2;
            instr_pkg::U_SLL:  result = src1 << shamt;
            instr_pkg::U_SRL:  result = src1 >> shamt;
            instr_pkg::U_SRA:  result = $signed(src1) >>> shamt;
            instr_pkg::U_SLT: begin
                result = {31'b0, $signed(src1) < $signed(src2)};
            end
            instr_pkg::U_SLTU: begin
                result = {31'b0, src1 < src2};
            end
            // Immediate arrives already shifted into place
            instr_pkg::U_LUI:  result = src2;
            default: begin
                resvld = 1'b0;
                result = '0;
            end
        endcase
    end

endmodule

// File: logic/ibr.sv
`timescale 1ns/1ps

module ibr (
    input  instr_pkg::t_uop     uop,
    input  instr_pkg::t_rv_data src1,
    input  instr_pkg::t_rv_data src2,
    input  instr_pkg::t_rv_data pc,
    input  instr_pkg::t_rv_data imm,
    input  logic                pred_taken,
    output logic                resvld,
    output instr_pkg::t_rv_data br_result,
    output logic                mispred
);

    logic                taken;
    logic                is_jal;
    instr_pkg::t_rv_data pc_next;
    instr_pkg::t_rv_data pc_target;

    assign resvld = instr_pkg::f_is_branch(uop);
    assign is_jal = (uop == instr_pkg::U_JAL);

    always_comb begin
        case (uop)
            instr_pkg::U_BEQ: taken = (src1 == src2);
            instr_pkg::U_BNE: taken = (src1 != src2);
            instr_pkg::U_BLT: taken = ($signed(src1) < $signed(src2));
            instr_pkg::U_BGE: taken = ($signed(src1) >= $signed(src2));
            instr_pkg::U_JAL: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign pc_next   = pc + 32'd4;
    assign pc_target = pc + imm;

    // Jumps report the link value, conditional branches the next fetch address
    always_comb begin
        if (taken && !is_jal) begin
            br_result = pc_target;
        end else begin
            br_result = pc_next;
        end
    end

    assign mispred = resvld & (taken != pred_taken);

endmodule

// File: logic/instr_pkg.sv
package instr_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] t_rv_data;

    typedef enum logic [4:0] {
        U_INVALID = 5'd0,
        U_ADD     = 5'd1,
        U_SUB     = 5'd2,
        U_AND     = 5'd3,
        U_OR      = 5'd4,
        U_XOR     = 5'd5,
        U_SLL     = 5'd6,
        U_SRL     = 5'd7,
        U_SRA     = 5'd8,
        U_SLT     = 5'd9,
        U_SLTU    = 5'd10,
        U_LUI     = 5'd11,
        U_BEQ     = 5'd12,
        U_BNE     = 5'd13,
        U_BLT     = 5'd14,
        U_BGE     = 5'd15,
        U_JAL     = 5'd16
    } t_uop;

    // Kind of operand or destination
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_REG  = 2'd1,
        OP_IMM  = 2'd2
    } t_optype;

    function automatic logic f_is_branch(t_uop uop);
        logic is_br;
        is_br = 1'b0;
        case (uop)
            U_BEQ, U_BNE, U_BLT, U_BGE, U_JAL: is_br = 1'b1;
            default: is_br = 1'b0;
        endcase
        return is_br;
    endfunction

endpackage

// File: logic/int_cluster.sv
`timescale 1ns/1ps

module int_cluster (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                br_mispred_rb1,
    input  logic                iss_valid,
    input  instr_pkg::t_uop     iss_uop,
    input  instr_pkg::t_optype  iss_src2_type,
    input  instr_pkg::t_optype  iss_dst_type,
    input  rob_pkg::t_prf_id    iss_psrc1,
    input  rob_pkg::t_prf_id    iss_psrc2,
    input  rob_pkg::t_prf_id    iss_pdst,
    input  rob_pkg::t_rob_id    iss_robid,
    input  instr_pkg::t_rv_data iss_imm,
    input  instr_pkg::t_rv_data iss_pc,
    input  logic                iss_pred_taken,
    output logic                wr_en,
    output rob_pkg::t_prf_id    wr_pdst,
    output instr_pkg::t_rv_data wr_data,
    output logic                ro_valid,
    output rob_pkg::t_rob_id    ro_robid,
    output logic                ro_mispred
);

    instr_pkg::t_rv_data rd1_data;
    instr_pkg::t_rv_data rd2_data;

    iprf u_iprf (
        .clk      (clk),
        .reset    (reset),
        .rd1_pdst (iss_psrc1),
        .rd1_data (rd1_data),
        .rd2_pdst (iss_psrc2),
        .rd2_data (rd2_data),
        .wr_en    (wr_en),
        .wr_pdst  (wr_pdst),
        .wr_data  (wr_data)
    );

    exe u_exe (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .iss_valid      (iss_valid),
        .iss_uop        (iss_uop),
        .iss_src2_type  (iss_src2_type),
        .iss_dst_type   (iss_dst_type),
        .rd1_data       (rd1_data),
        .rd2_data       (rd2_data),
        .iss_imm        (iss_imm),
        .iss_pc         (iss_pc),
        .iss_pred_taken (iss_pred_taken),
        .iss_pdst       (iss_pdst),
        .iss_robid      (iss_robid),
        .br_mispred_rb1 (br_mispred_rb1),
        .wr_en          (wr_en),
        .wr_pdst        (wr_pdst),
        .wr_data        (wr_data),
        .ro_valid       (ro_valid),
        .ro_robid       (ro_robid),
        .ro_mispred     (ro_mispred)
    );

endmodule

// File: logic/iprf.sv
`timescale 1ns/1ps

module iprf (
    input  logic                clk,
    input  logic                reset,
    input  rob_pkg::t_prf_id    rd1_pdst,
    output instr_pkg::t_rv_data rd1_data,
    input  rob_pkg::t_prf_id    rd2_pdst,
    output instr_pkg::t_rv_data rd2_data,
    input  logic                wr_en,
    input  rob_pkg::t_prf_id    wr_pdst,
    input  instr_pkg::t_rv_data wr_data
);

    instr_pkg::t_rv_data regs [rob_pkg::num_prf];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rob_pkg::num_prf; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_pdst] <= wr_data;
        end
    end

    // Register 0 is hardwired to zero
    always_comb begin
        if (rd1_pdst == '0) begin
            rd1_data = '0;
        end else begin
            rd1_data = regs[rd1_pdst];
        end
    end

    always_comb begin
        if (rd2_pdst == '0) begin
            rd2_data = '0;
        end else begin
            rd2_data = regs[rd2_pdst];
        end
    end

    a_no_wr_zero: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> (wr_pdst != '0)
    ) else $error("iprf: write to physical register 0");

endmodule

// File: logic/rob_pkg.sv
package rob_pkg;

    // Physical register file
    localparam int num_prf = 32;
    localparam int prf_id_bits = $clog2(num_prf);

    typedef logic [prf_id_bits-1:0] t_prf_id;

    // Reorder buffer
    localparam int num_rob = 64;
    localparam int rob_id_bits = $clog2(num_rob);

    typedef logic [rob_id_bits-1:0] t_rob_id;

endpackage

// File: sim/int_cluster_tb.sv
`timescale 1ns/1ps

module int_cluster_tb;

    // Roughly 250 cycles of tests after reset, limit leaves a wide margin
    localparam int max_cycles = 2000;

    typedef struct packed {
        logic                wr;
        rob_pkg::t_prf_id    pdst;
        instr_pkg::t_rv_data data;
        rob_pkg::t_rob_id    robid;
        logic                mispred;
    } t_expect;

    logic                clk;
    logic                reset;
    logic                stall;
    logic                br_mispred_rb1;
    logic                iss_valid;
    instr_pkg::t_uop     iss_uop;
    instr_pkg::t_optype  iss_src2_type;
    instr_pkg::t_optype  iss_dst_type;
    rob_pkg::t_prf_id    iss_psrc1;
    rob_pkg::t_prf_id    iss_psrc2;
    rob_pkg::t_prf_id    iss_pdst;
    rob_pkg::t_rob_id    iss_robid;
    instr_pkg::t_rv_data iss_imm;
    instr_pkg::t_rv_data iss_pc;
    logic                iss_pred_taken;
    logic                wr_en;
    rob_pkg::t_prf_id    wr_pdst;
    instr_pkg::t_rv_data wr_data;
    logic                ro_valid;
    rob_pkg::t_rob_id    ro_robid;
    logic                ro_mispred;

    // Register file contents as the testbench expects them
    logic [31:0]         model [32];
    rob_pkg::t_rob_id    robid_ctr;
    integer              seed;
    int                  errors;
    int                  checks;
    int                  cycles = 0;

    int_cluster dut0 (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .br_mispred_rb1 (br_mispred_rb1),
        .iss_valid      (iss_valid),
        .iss_uop        (iss_uop),
        .iss_src2_type  (iss_src2_type),
        .iss_dst_type   (iss_dst_type),
        .iss_psrc1      (iss_psrc1),
        .iss_psrc2      (iss_psrc2),
        .iss_pdst       (iss_pdst),
        .iss_robid      (iss_robid),
        .iss_imm        (iss_imm),
        .iss_pc         (iss_pc),
        .iss_pred_taken (iss_pred_taken),
        .wr_en          (wr_en),
        .wr_pdst        (wr_pdst),
        .wr_data        (wr_data),
        .ro_valid       (ro_valid),
        .ro_robid       (ro_robid),
        .ro_mispred     (ro_mispred)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run went past %0d cycles", max_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] alu_ref(instr_pkg::t_uop uop, logic [31:0] a,
                                            logic [31:0] b);
        logic [31:0] res;
        res = 32'd0;
        case (uop)
            instr_pkg::U_ADD:  res = a + b;
            instr_pkg::U_SUB:  res = a - b;
            instr_pkg::U_AND:  res = a & b;
            instr_pkg::U_OR:   res = a | b;
            instr_pkg::U_XOR:  res = a ^ b;
            instr_pkg::U_SLL:  res = a << b[4:0];
            instr_pkg::U_SRL:  res = a >> b[4:0];
            instr_pkg::U_SRA:  res = $signed(a) >>> b[4:0];
            instr_pkg::U_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            instr_pkg::U_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            instr_pkg::U_LUI:  res = b;
            default:           res = 32'd0;
        endcase
        return res;
    endfunction

    function automatic t_expect predict(instr_pkg::t_uop uop, instr_pkg::t_optype src2_type,
                                        instr_pkg::t_optype dst_type, logic [4:0] psrc1,
                                        logic [4:0] psrc2, logic [4:0] pdst, logic [31:0] imm,
                                        logic [31:0] pc, logic pred);
        t_expect     e;
        logic [31:0] a;
        logic [31:0] b;
        logic        is_br;
        logic        taken;
        a = model[psrc1];
        b = 32'd0;
        if (src2_type == instr_pkg::OP_REG) begin
            b = model[psrc2];
        end else if (src2_type == instr_pkg::OP_IMM) begin
            b = imm;
        end
        is_br = 1'b1;
        taken = 1'b0;
        case (uop)
            instr_pkg::U_BEQ: taken = (a == b);
            instr_pkg::U_BNE: taken = (a != b);
            instr_pkg::U_BLT: taken = ($signed(a) < $signed(b));
            instr_pkg::U_BGE: taken = ($signed(a) >= $signed(b));
            instr_pkg::U_JAL: taken = 1'b1;
            default:          is_br = 1'b0;
        endcase
        if (is_br) begin
            e.data    = (taken && uop != instr_pkg::U_JAL) ? pc + imm : pc + 32'd4;
            e.mispred = (taken != pred);
        end else begin
            e.data    = alu_ref(uop, a, b);
            e.mispred = 1'b0;
        end
        e.wr    = (dst_type == instr_pkg::OP_REG);
        e.pdst  = pdst;
        e.robid = robid_ctr;
        return e;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic check_entry(input t_expect e);
        check_value("ro_valid", 32'(ro_valid), 32'd1);
        check_value("ro_robid", 32'(ro_robid), 32'(e.robid));
        check_value("ro_mispred", 32'(ro_mispred), 32'(e.mispred));
        check_value("wr_en", 32'(wr_en), 32'(e.wr));
        check_value("wr_data", wr_data, e.data);
        if (e.wr) begin
            check_value("wr_pdst", 32'(wr_pdst), 32'(e.pdst));
        end
    endtask

    // Write lands at the edge that closes the EX1 cycle
    task automatic commit(input t_expect e);
        if (e.wr) begin
            model[e.pdst] = e.data;
        end
    endtask

    task automatic idle();
        iss_valid = 1'b0;
        iss_uop   = instr_pkg::U_INVALID;
    endtask

    task automatic issue_op(input instr_pkg::t_uop uop, input instr_pkg::t_optype src2_type,
                            input instr_pkg::t_optype dst_type, input logic [4:0] psrc1,
                            input logic [4:0] psrc2, input logic [4:0] pdst,
                            input logic [31:0] imm, input logic [31:0] pc, input logic pred,
                            output t_expect e);
        e              = predict(uop, src2_type, dst_type, psrc1, psrc2, pdst, imm, pc, pred);
        iss_valid      = 1'b1;
        iss_uop        = uop;
        iss_src2_type  = src2_type;
        iss_dst_type   = dst_type;
        iss_psrc1      = psrc1;
        iss_psrc2      = psrc2;
        iss_pdst       = pdst;
        iss_robid      = robid_ctr;
        iss_imm        = imm;
        iss_pc         = pc;
        iss_pred_taken = pred;
        robid_ctr      = robid_ctr + 6'd1;
    endtask

    // One micro-op, then a gap so the next one reads the written value
    task automatic run_op(input instr_pkg::t_uop uop, input instr_pkg::t_optype src2_type,
                          input instr_pkg::t_optype dst_type, input logic [4:0] psrc1,
                          input logic [4:0] psrc2, input logic [4:0] pdst,
                          input logic [31:0] imm, input logic [31:0] pc, input logic pred);
        t_expect e;
        issue_op(uop, src2_type, dst_type, psrc1, psrc2, pdst, imm, pc, pred, e);
        next_cycle();
        idle();
        check_entry(e);
        commit(e);
        next_cycle();
    endtask

    task automatic test_reg_writes();
        for (int i = 1; i < 8; i++) begin
            run_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0,
                   i[4:0], 32'(i) * 32'h1111_1111, 32'd0, 1'b0);
        end
    endtask

    task automatic test_alu_ops();
        logic [31:0] r;
        logic [31:0] imm;
        for (int i = 8; i < 16; i++) begin
            r = $random(seed);
            run_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0,
                   i[4:0], r, 32'd0, 1'b0);
        end
        // Codes 1 to 11 are U_ADD through U_LUI
        for (int k = 1; k <= 11; k++) begin
            for (int n = 0; n < 2; n++) begin
                r = $random(seed);
                imm = $random(seed);
                run_op(instr_pkg::t_uop'(k[4:0]), instr_pkg::OP_REG, instr_pkg::OP_REG,
                       {2'b01, r[2:0]}, {2'b01, r[5:3]}, {1'b1, r[9:6]}, 32'd0, 32'd0, 1'b0);
                run_op(instr_pkg::t_uop'(k[4:0]), instr_pkg::OP_IMM, instr_pkg::OP_REG,
                       {2'b01, r[12:10]}, 5'd0, {1'b1, r[16:13]}, imm, 32'd0, 1'b0);
            end
        end
    endtask

    task automatic test_branches();
        logic [4:0]  lhs [4] = '{5'd8, 5'd8, 5'd10, 5'd8};
        logic [4:0]  rhs [4] = '{5'd9, 5'd11, 5'd8, 5'd10};
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] imm;
        run_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0, 5'd8,
               32'd5, 32'd0, 1'b0);
        run_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0, 5'd9,
               32'd5, 32'd0, 1'b0);
        run_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0, 5'd10,
               32'hffff_fffd, 32'd0, 1'b0);
        run_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0, 5'd11,
               32'd7, 32'd0, 1'b0);
        // Codes 12 to 15 are the conditional branches
        for (int k = 12; k <= 15; k++) begin
            for (int p = 0; p < 4; p++) begin
                for (int t = 0; t < 2; t++) begin
                    r = $random(seed);
                    pc = {r[31:2], 2'b00};
                    imm = r[20] ? 32'hffff_ffe0 : 32'h0000_0040;
                    run_op(instr_pkg::t_uop'(k[4:0]), instr_pkg::OP_REG, instr_pkg::OP_NONE,
                           lhs[p], rhs[p], 5'd12, imm, pc, t[0]);
                end
            end
        end
        for (int t = 0; t < 2; t++) begin
            r = $random(seed);
            run_op(instr_pkg::U_JAL, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0, 5'd20,
                   32'h0000_0800, {r[31:2], 2'b00}, t[0]);
        end
    endtask

    task automatic test_stall();
        t_expect first;
        t_expect second;
        issue_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd1, 5'd0, 5'd21,
                 32'h0000_0abc, 32'd0, 1'b0, first);
        next_cycle();
        issue_op(instr_pkg::U_XOR, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd2, 5'd0, 5'd22,
                 32'h00ff_00ff, 32'd0, 1'b0, second);
        stall = 1'b1;
        check_entry(first);
        commit(first);
        repeat (3) begin
            next_cycle();
            check_entry(first);
        end
        stall = 1'b0;
        next_cycle();
        idle();
        check_entry(second);
        commit(second);
        next_cycle();
    endtask

    task automatic test_flush();
        t_expect lost;
        run_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0, 5'd23,
               32'h0000_5a5a, 32'd0, 1'b0);
        issue_op(instr_pkg::U_ADD, instr_pkg::OP_IMM, instr_pkg::OP_REG, 5'd0, 5'd0, 5'd23,
                 32'h1234_5678, 32'd0, 1'b0, lost);
        br_mispred_rb1 = 1'b1;
        next_cycle();
        idle();
        br_mispred_rb1 = 1'b0;
        check_value("ro_valid", 32'(ro_valid), 32'd0);
        check_value("wr_en", 32'(wr_en), 32'd0);
        next_cycle();
        // Reading r23 back shows whether the flushed write got through
        run_op(instr_pkg::U_OR, instr_pkg::OP_REG, instr_pkg::OP_REG, 5'd23, 5'd0, 5'd24,
               32'd0, 32'd0, 1'b0);
    endtask

    task automatic test_back_to_back();
        t_expect e;
        for (int i = 0; i < 6; i++) begin
            issue_op(i[0] ? instr_pkg::U_XOR : instr_pkg::U_ADD, instr_pkg::OP_REG,
                     instr_pkg::OP_REG, i[4:0] + 5'd1, 5'd7, i[4:0] + 5'd25, 32'd0, 32'd0,
                     1'b0, e);
            next_cycle();
            check_entry(e);
            commit(e);
        end
        idle();
        next_cycle();
        check_value("ro_valid", 32'(ro_valid), 32'd0);
    endtask

    initial begin
        seed           = 32'h6f7b_b734;
        errors         = 0;
        checks         = 0;
        robid_ctr      = '0;
        reset          = 1'b1;
        stall          = 1'b0;
        br_mispred_rb1 = 1'b0;
        iss_valid      = 1'b0;
        iss_uop        = instr_pkg::U_INVALID;
        iss_src2_type  = instr_pkg::OP_NONE;
        iss_dst_type   = instr_pkg::OP_NONE;
        iss_psrc1      = '0;
        iss_psrc2      = '0;
        iss_pdst       = '0;
        iss_robid      = '0;
        iss_imm        = '0;
        iss_pc         = '0;
        iss_pred_taken = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reg_writes();
        test_alu_ops();
        test_branches();
        test_stall();
        test_flush();
        test_back_to_back();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/instr_pkg.sv
logic/rob_pkg.sv
logic/ialu.sv
logic/ibr.sv
logic/exe_stage_reg.sv
logic/exe.sv
logic/iprf.sv
logic/int_cluster.sv
sim/int_cluster_tb.sv
